//--- Bender.yml
package:
  name: lc4_superscalar

sources:
  - rtl/lc4_isa_pkg.sv
  - rtl/lc4_pipe_pkg.sv
  - rtl/lc4_decoder.sv
  - rtl/lc4_alu.sv
  - rtl/lc4_regfile_ss.sv
  - rtl/lc4_hazard_unit.sv
  - rtl/lc4_bypass.sv
  - rtl/lc4_lane.sv
  - rtl/lc4_superscalar.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lc4_superscalar_asserts.sv
      - bench/lc4_superscalar_tb.sv

//--- bench/lc4_superscalar_asserts.sv
`timescale 1ns/1ps

module lc4_superscalar_asserts import lc4_pipe_pkg::*; (
    input logic    gwe,
    input logic    i_reset,
    input retire_t i_retire_a,
    input retire_t i_retire_b,
    input logic    i_req_a,
    input logic    i_req_b
);

    int fail_count = 0;

    // slot A is always the older one
    retire_order: assert property (@(posedge gwe) disable iff (i_reset)
        (i_retire_a.valid && i_retire_b.valid) |-> (i_retire_b.pc > i_retire_a.pc))
    else begin
        fail_count++;
        $error("slot B retired an older pc than slot A");
    end

    one_mem_lane: assert property (@(posedge gwe) disable iff (i_reset)
        !(i_req_a && i_req_b))
    else begin
        fail_count++;
        $error("both lanes requested the data memory port");
    end

    quiet_after_reset: assert property (@(posedge gwe)
        i_reset |=> (!i_retire_a.valid && !i_retire_b.valid))
    else begin
        fail_count++;
        $error("a retire port was valid right after reset");
    end

endmodule

//--- bench/lc4_tb_model.svh
`ifndef LC4_TB_MODEL_SVH
`define LC4_TB_MODEL_SVH

// architectural state of the in-order model
word_t model_regs [8];
word_t model_mem [word_t];

function automatic word_t sign_extend(word_t v, int w);
    word_t top;
    word_t mask;
    top  = word_t'(1) << (w - 1);
    mask = (word_t'(1) << w) - word_t'(1);
    return ((v & mask) ^ top) - top;
endfunction

// background data memory contents that depend on every address bit
function automatic word_t fill_word(word_t a);
    return {a[7:0], a[15:8]} ^ 16'h3c5a;
endfunction

function automatic word_t load_word(word_t a);
    if (model_mem.exists(a)) begin
        return model_mem[a];
    end
    return fill_word(a);
endfunction

function automatic void clear_model();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_mem.delete();
endfunction

// runs one instruction and returns the record it should retire with
function automatic retire_t execute_insn(word_t pc, word_t insn);
    retire_t r;
    word_t   rs_v;
    word_t   rt_v;
    word_t   addr;
    word_t   res;
    logic    wr;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = pc;
    r.insn  = insn;
    rs_v    = model_regs[insn[8:6]];
    rt_v    = model_regs[insn[2:0]];
    wr      = 1'b0;
    res     = '0;
    case (insn[15:12])
        4'b0001: begin
            wr = insn[5] || insn[5:3] == 3'b000 || insn[5:3] == 3'b010;
            if (insn[5]) begin
                res = rs_v + sign_extend(insn, 5);
            end else if (insn[5:3] == 3'b010) begin
                res = rs_v - rt_v;
            end else begin
                res = rs_v + rt_v;
            end
        end
        4'b0101: begin
            wr  = insn[5] || insn[5:3] == 3'b000;
            res = rs_v & (insn[5] ? sign_extend(insn, 5) : rt_v);
        end
        4'b0110: begin
            addr        = rs_v + sign_extend(insn, 6);
            res         = load_word(addr);
            wr          = 1'b1;
            r.dmem_addr = addr;
            r.dmem_data = res;
        end
        4'b0111: begin
            addr            = rs_v + sign_extend(insn, 6);
            r.dmem_we       = 1'b1;
            r.dmem_addr     = addr;
            r.dmem_data     = model_regs[insn[11:9]];
            model_mem[addr] = model_regs[insn[11:9]];
        end
        4'b1001: begin
            res = sign_extend(insn, 9);
            wr  = 1'b1;
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    if (wr) begin
        model_regs[insn[11:9]] = res;
        r.rf_we   = 1'b1;
        r.wsel    = insn[11:9];
        r.rf_data = res;
    end
    return r;
endfunction

function automatic word_t add_insn(reg_sel_t rd, reg_sel_t rs, reg_sel_t rt);
    return {4'b0001, rd, rs, 3'b000, rt};
endfunction

function automatic word_t sub_insn(reg_sel_t rd, reg_sel_t rs, reg_sel_t rt);
    return {4'b0001, rd, rs, 3'b010, rt};
endfunction

function automatic word_t and_insn(reg_sel_t rd, reg_sel_t rs, reg_sel_t rt);
    return {4'b0101, rd, rs, 3'b000, rt};
endfunction

function automatic word_t addi_insn(reg_sel_t rd, reg_sel_t rs, logic [4:0] imm);
    return {4'b0001, rd, rs, 1'b1, imm};
endfunction

function automatic word_t andi_insn(reg_sel_t rd, reg_sel_t rs, logic [4:0] imm);
    return {4'b0101, rd, rs, 1'b1, imm};
endfunction

function automatic word_t const_insn(reg_sel_t rd, logic [8:0] imm);
    return {4'b1001, rd, imm};
endfunction

function automatic word_t ldr_insn(reg_sel_t rd, reg_sel_t rs, logic [5:0] ofs);
    return {4'b0110, rd, rs, ofs};
endfunction

// the data register goes in the rd field
function automatic word_t str_insn(reg_sel_t rt, reg_sel_t rs, logic [5:0] ofs);
    return {4'b0111, rt, rs, ofs};
endfunction

`endif

//--- bench/lc4_superscalar_tb.sv
`timescale 1ns/1ps

module lc4_superscalar_tb import lc4_isa_pkg::*, lc4_pipe_pkg::*;;

    localparam word_t RESET_PC     = 16'h8200;
    localparam int    IMEM_DEPTH   = 64;
    localparam int    RESET_CYCLES = 8;
    localparam int    NUM_TESTS    = 5;
    localparam int    DRAIN_CYCLES = 24;
    // every program fits in IMEM_DEPTH and retires within four cycles per word
    localparam int    TIMEOUT = NUM_TESTS * (IMEM_DEPTH * 4 + RESET_CYCLES + DRAIN_CYCLES);

    logic    gwe;
    logic    i_reset;
    word_t   cur_pc;
    word_t   insn_a;
    word_t   insn_b;
    word_t   dmem_addr;
    word_t   dmem_towrite;
    logic    dmem_we;
    word_t   dmem_data;
    retire_t retire_a;
    retire_t retire_b;

    word_t       imem [IMEM_DEPTH];
    word_t       dmem [65536];
    word_t       ofs_a;
    word_t       ofs_b;
    word_t       prog [$];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycle;
    int          total;

    `include "lc4_tb_model.svh"

    lc4_superscalar #(.RESET_PC(RESET_PC)) i_lc4_superscalar (
        .gwe(gwe), .i_reset(i_reset), .o_cur_pc(cur_pc),
        .i_insn_a(insn_a), .i_insn_b(insn_b),
        .o_dmem_addr(dmem_addr), .o_dmem_towrite(dmem_towrite), .o_dmem_we(dmem_we),
        .i_dmem_data(dmem_data), .o_retire_a(retire_a), .o_retire_b(retire_b)
    );

    bind lc4_superscalar lc4_superscalar_asserts u_asserts (
        .gwe(gwe), .i_reset(i_reset), .i_retire_a(o_retire_a), .i_retire_b(o_retire_b),
        .i_req_a(req_a), .i_req_b(req_b)
    );

    initial begin
        gwe = 1'b0;
    end

    always #5 gwe = ~gwe;

    // memories answer in the same cycle and words past the program are nops
    assign ofs_a     = cur_pc - RESET_PC;
    assign ofs_b     = cur_pc + word_t'(1) - RESET_PC;
    assign insn_a    = (ofs_a < IMEM_DEPTH) ? imem[ofs_a[5:0]] : 16'h0000;
    assign insn_b    = (ofs_b < IMEM_DEPTH) ? imem[ofs_b[5:0]] : 16'h0000;
    assign dmem_data = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_towrite;
        end
    end

    always @(posedge gwe) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    // one of r4..r7
    function automatic reg_sel_t upper_reg();
        logic [15:0] v;
        v = rand_bits(2);
        return {1'b1, v[1:0]};
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_retire(string name, retire_t exp, retire_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(logic cond, string msg);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 16'h0000;
        end
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = fill_word(word_t'(a));
        end
    endtask

    task automatic apply_reset();
        @(posedge gwe);
        i_reset <= 1'b1;
        @(posedge gwe);
        load_memories();
        repeat (RESET_CYCLES - 1) @(posedge gwe);
        i_reset <= 1'b0;
    endtask

    // runs prog from reset and compares every retire record with the model
    task automatic run_program(string name, logic pairs);
        retire_t exp_q [$];
        retire_t got_q [$];
        int      got_cyc [$];
        int      n;
        int      c;
        word_t   exp_w;
        n = prog.size();
        apply_reset();
        clear_model();
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(execute_insn(RESET_PC + word_t'(i), prog[i]));
        end
        c = 0;
        while (got_q.size() < n) begin
            @(negedge gwe);
            c++;
            if (retire_a.valid === 1'b1) begin
                got_q.push_back(retire_a);
                got_cyc.push_back(c);
            end
            if (retire_b.valid === 1'b1) begin
                got_q.push_back(retire_b);
                got_cyc.push_back(c);
            end
        end
        for (int i = 0; i < n; i++) begin
            check_retire(name, exp_q[i], got_q[i]);
        end
        if (pairs) begin
            for (int i = 0; i + 1 < n; i += 2) begin
                check_true(got_cyc[i] == got_cyc[i + 1],
                           $sformatf("%s: pair at %0d did not retire in one cycle", name, i));
            end
        end
        // the data memory port must have left exactly the model's stores behind
        for (int a = 0; a < 65536; a++) begin
            exp_w = load_word(word_t'(a));
            if (dmem[a] !== exp_w) begin
                check_word($sformatf("%s dmem[%h]", name, word_t'(a)), exp_w, dmem[a]);
            end
        end
    endtask

    task automatic reset_behavior();
        retire_t exp_a;
        retire_t exp_b;
        prog = {const_insn(3'd1, 9'h0a5), const_insn(3'd2, 9'h13c)};
        apply_reset();
        clear_model();
        exp_a = execute_insn(RESET_PC, prog[0]);
        exp_b = execute_insn(RESET_PC + word_t'(1), prog[1]);
        @(negedge gwe);
        check_word("reset_pc", RESET_PC, cur_pc);
        check_true(dmem_we === 1'b0, "data memory write enable was high after reset");
        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                @(negedge gwe);
            end
            check_true(retire_a.valid === 1'b0 && retire_b.valid === 1'b0,
                       "a retire port went valid before the first writeback");
        end
        @(negedge gwe);
        check_retire("reset_first_a", exp_a, retire_a);
        check_retire("reset_first_b", exp_b, retire_b);
    endtask

    task automatic independent_pairs();
        logic [15:0] imm;
        reg_sel_t    rd_a;
        reg_sel_t    rd_b;
        prog.delete();
        // A writes r0..r3 while B writes and reads only r4..r7
        for (int k = 0; k < 12; k++) begin
            rd_a = reg_sel_t'(k % 4);
            rd_b = reg_sel_t'(4 + k % 4);
            case (k % 3)
                0: begin
                    imm = rand_bits(9);
                    prog.push_back(const_insn(rd_a, imm[8:0]));
                    imm = rand_bits(9);
                    prog.push_back(const_insn(rd_b, imm[8:0]));
                end
                1: begin
                    imm = rand_bits(5);
                    prog.push_back(addi_insn(rd_a, upper_reg(), imm[4:0]));
                    prog.push_back(add_insn(rd_b, upper_reg(), upper_reg()));
                end
                default: begin
                    imm = rand_bits(5);
                    prog.push_back(andi_insn(rd_a, upper_reg(), imm[4:0]));
                    prog.push_back(sub_insn(rd_b, upper_reg(), upper_reg()));
                end
            endcase
        end
        run_program("independent_pairs", 1'b1);
    endtask

    task automatic dependent_chains();
        logic [15:0] imm;
        prog.delete();
        imm = rand_bits(9);
        prog.push_back(const_insn(3'd1, imm[8:0]));
        for (int k = 0; k < 8; k++) begin
            imm = rand_bits(5);
            prog.push_back(addi_insn(3'd2, 3'd1, imm[4:0]));
            prog.push_back(add_insn(3'd3, 3'd2, 3'd1));
            prog.push_back(sub_insn(3'd1, 3'd3, 3'd2));
            prog.push_back(and_insn(3'd4, 3'd1, 3'd3));
        end
        run_program("dependent_chains", 1'b0);
    endtask

    task automatic load_use();
        logic [15:0] imm;
        prog.delete();
        imm = rand_bits(9);
        prog.push_back(const_insn(3'd1, imm[8:0]));
        for (int k = 0; k < 6; k++) begin
            imm = rand_bits(6);
            prog.push_back(ldr_insn(3'd2, 3'd1, imm[5:0]));
            prog.push_back(add_insn(3'd3, 3'd2, 3'd2));
            imm = rand_bits(5);
            prog.push_back(addi_insn(3'd5, 3'd5, imm[4:0]));
            imm = rand_bits(6);
            prog.push_back(ldr_insn(3'd6, 3'd1, imm[5:0]));
            prog.push_back(and_insn(3'd7, 3'd6, 3'd3));
            imm = rand_bits(6);
            prog.push_back(ldr_insn(3'd4, 3'd3, imm[5:0]));
            prog.push_back(add_insn(3'd5, 3'd4, 3'd5));
        end
        run_program("load_use", 1'b0);
    endtask

    task automatic memory_pairs();
        logic [15:0] imm;
        logic [5:0]  ofs;
        prog.delete();
        imm = rand_bits(9);
        prog.push_back(const_insn(3'd1, imm[8:0]));
        for (int k = 0; k < 6; k++) begin
            imm = rand_bits(5);
            ofs = {1'b0, imm[4:0]};
            imm = rand_bits(5);
            prog.push_back(addi_insn(3'd2, 3'd2, imm[4:0]));
            prog.push_back(str_insn(3'd2, 3'd1, ofs));
            prog.push_back(ldr_insn(3'd3, 3'd1, ofs));
            prog.push_back(add_insn(3'd4, 3'd3, 3'd2));
            prog.push_back(str_insn(3'd4, 3'd1, ofs + 6'd1));
            prog.push_back(ldr_insn(3'd5, 3'd1, ofs + 6'd1));
            imm = rand_bits(6);
            prog.push_back(str_insn(3'd5, 3'd1, imm[5:0]));
        end
        run_program("memory_pairs", 1'b0);
    endtask

    initial begin
        i_reset = 1'b1;
        lfsr_q  = 32'he24f06b9;
        errors  = 0;
        checks  = 0;
        cycle   = 0;
        reset_behavior();
        independent_pairs();
        dependent_chains();
        load_use();
        memory_pairs();
        total = errors + i_lc4_superscalar.u_asserts.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, i_lc4_superscalar.u_asserts.fail_count);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+bench
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_alu.sv
rtl/lc4_regfile_ss.sv
rtl/lc4_hazard_unit.sv
rtl/lc4_bypass.sv
rtl/lc4_lane.sv
rtl/lc4_superscalar.sv
bench/lc4_superscalar_asserts.sv
bench/lc4_superscalar_tb.sv

//--- rtl/lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu import lc4_isa_pkg::*; (
    input  word_t i_insn,
    input  word_t i_rs,
    input  word_t i_rt,
    output word_t o_result
);

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t opnd;

    assign imm5 = {{(XLEN-IMM5_W){i_insn[IMM5_W-1]}}, i_insn[IMM5_W-1:0]};
    assign imm6 = {{(XLEN-IMM6_W){i_insn[IMM6_W-1]}}, i_insn[IMM6_W-1:0]};
    assign imm9 = {{(XLEN-IMM9_W){i_insn[IMM9_W-1]}}, i_insn[IMM9_W-1:0]};

    // second operand for ADD and AND
    assign opnd = i_insn[IMM_BIT] ? imm5 : i_rt;

    always_comb begin
        case (i_insn[OPC_LSB +: OPC_W])
            OP_ARITH: begin
                if (!i_insn[IMM_BIT] && i_insn[SUBOP_LSB +: 3] == SUBOP_SUB) begin
                    o_result = i_rs - i_rt;
                end else begin
                    o_result = i_rs + opnd;
                end
            end
            OP_AND:           o_result = i_rs & opnd;
            OP_LDR, OP_STR:   o_result = i_rs + imm6;
            OP_CONST:         o_result = imm9;
            default:          o_result = '0;
        endcase
    end

endmodule

//--- rtl/lc4_bypass.sv
`timescale 1ns/1ps

module lc4_bypass import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  slot_t i_x_a,
    input  slot_t i_x_b,
    input  word_t i_rf_rs_a,
    input  word_t i_rf_rt_a,
    input  word_t i_rf_rs_b,
    input  word_t i_rf_rt_b,
    input  fwd_t  i_m_a,
    input  fwd_t  i_m_b,
    input  fwd_t  i_w_a,
    input  fwd_t  i_w_b,
    input  slot_t i_m_slot_a,
    input  slot_t i_m_slot_b,
    input  word_t i_m_rt_a,
    input  word_t i_m_rt_b,
    output word_t o_rs_a,
    output word_t o_rt_a,
    output word_t o_rs_b,
    output word_t o_rt_b,
    output word_t o_st_a,
    output word_t o_st_b
);

    function automatic logic hit(fwd_t f, reg_sel_t r);
        return f.we && f.rd == r;
    endfunction

    // youngest producer wins with M over W and B over A
    function automatic word_t x_operand(reg_sel_t r, word_t rf_val);
        if (hit(i_m_b, r)) return i_m_b.value;
        if (hit(i_m_a, r)) return i_m_a.value;
        if (hit(i_w_b, r)) return i_w_b.value;
        if (hit(i_w_a, r)) return i_w_a.value;
        return rf_val;
    endfunction

    // store data catches up with writers now in W
    function automatic word_t wm_data(reg_sel_t r, word_t own);
        if (hit(i_w_b, r)) return i_w_b.value;
        if (hit(i_w_a, r)) return i_w_a.value;
        return own;
    endfunction

    assign o_rs_a = x_operand(i_x_a.dec.rs, i_rf_rs_a);
    assign o_rt_a = x_operand(i_x_a.dec.rt, i_rf_rt_a);
    assign o_rs_b = x_operand(i_x_b.dec.rs, i_rf_rs_b);
    assign o_rt_b = x_operand(i_x_b.dec.rt, i_rf_rt_b);

    assign o_st_a = wm_data(i_m_slot_a.dec.rt, i_m_rt_a);

    // A's result in M is younger than anything in W
    assign o_st_b = hit(i_m_a, i_m_slot_b.dec.rt) ? i_m_a.value :
                    wm_data(i_m_slot_b.dec.rt, i_m_rt_b);

endmodule

//--- rtl/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder import lc4_isa_pkg::*; (
    input  word_t    i_insn,
    output decoded_t o_dec
);

    logic [2:0] subop;
    logic       imm_form;

    assign subop    = i_insn[SUBOP_LSB +: 3];
    assign imm_form = i_insn[IMM_BIT];

    always_comb begin
        o_dec    = '0;
        o_dec.rs = i_insn[RS_LSB +: REG_SEL_W];
        o_dec.rt = i_insn[RT_LSB +: REG_SEL_W];
        o_dec.rd = i_insn[RD_LSB +: REG_SEL_W];
        case (i_insn[OPC_LSB +: OPC_W])
            OP_ARITH: begin
                if (imm_form) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rf_we = 1'b1;
                end else if (subop == SUBOP_ADD || subop == SUBOP_SUB) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rt_re = 1'b1;
                    o_dec.rf_we = 1'b1;
                end
            end
            OP_AND: begin
                if (imm_form) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rf_we = 1'b1;
                end else if (subop == SUBOP_AND) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rt_re = 1'b1;
                    o_dec.rf_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_dec.rs_re   = 1'b1;
                o_dec.rf_we   = 1'b1;
                o_dec.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_dec.rt       = i_insn[RD_LSB +: REG_SEL_W];
                o_dec.rs_re    = 1'b1;
                o_dec.rt_re    = 1'b1;
                o_dec.is_store = 1'b1;
            end
            OP_CONST: begin
                o_dec.rf_we = 1'b1;
            end
            default: begin
                o_dec.rf_we = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/lc4_hazard_unit.sv
`timescale 1ns/1ps

module lc4_hazard_unit import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  slot_t i_d_a,
    input  slot_t i_d_b,
    input  slot_t i_x_a,
    input  slot_t i_x_b,
    output logic  o_switch,
    output logic  o_stall,
    output logic  o_bubble_b
);

    logic ltu_a;
    logic ltu_b;
    logic b_needs_a;
    logic both_mem;

    // operands consumed in execute while store data waits for M
    function automatic logic reads_in_x(slot_t s, reg_sel_t r);
        return s.valid && ((s.dec.rs_re && s.dec.rs == r) ||
                           (s.dec.rt_re && !s.dec.is_store && s.dec.rt == r));
    endfunction

    // a load in execute that is still the newest writer of r
    function automatic logic load_pending(reg_sel_t r);
        logic ld_b;
        logic wr_b;
        logic ld_a;
        ld_b = i_x_b.valid && i_x_b.dec.is_load && i_x_b.dec.rd == r;
        wr_b = i_x_b.valid && i_x_b.dec.rf_we && i_x_b.dec.rd == r;
        ld_a = i_x_a.valid && i_x_a.dec.is_load && i_x_a.dec.rd == r;
        return ld_b || (ld_a && !wr_b);
    endfunction

    function automatic logic load_use(slot_t d);
        return (reads_in_x(d, d.dec.rs) && d.dec.rs_re && load_pending(d.dec.rs)) ||
               (reads_in_x(d, d.dec.rt) && d.dec.rt_re && load_pending(d.dec.rt));
    endfunction

    assign ltu_a = load_use(i_d_a);
    assign ltu_b = load_use(i_d_b);

    assign b_needs_a = i_d_a.valid && i_d_a.dec.rf_we && reads_in_x(i_d_b, i_d_a.dec.rd);

    // one data memory port
    assign both_mem = i_d_a.valid && i_d_b.valid &&
                      (i_d_a.dec.is_load || i_d_a.dec.is_store) &&
                      (i_d_b.dec.is_load || i_d_b.dec.is_store);

    assign o_stall    = ltu_a;
    assign o_switch   = !ltu_a && i_d_a.valid && (b_needs_a || both_mem || ltu_b);
    assign o_bubble_b = o_stall || o_switch;

endmodule

//--- rtl/lc4_isa_pkg.sv
package lc4_isa_pkg;

    localparam int unsigned XLEN      = 16;
    localparam int unsigned REG_SEL_W = 3;
    localparam int unsigned OPC_W     = 4;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    // lsb of each instruction field
    localparam int unsigned OPC_LSB   = 12;
    localparam int unsigned RD_LSB    = 9;
    localparam int unsigned RS_LSB    = 6;
    localparam int unsigned RT_LSB    = 0;
    localparam int unsigned SUBOP_LSB = 3;
    localparam int unsigned IMM_BIT   = 5;

    localparam int unsigned IMM5_W = 5;
    localparam int unsigned IMM6_W = 6;
    localparam int unsigned IMM9_W = 9;

    typedef enum logic [OPC_W-1:0] {
        OP_ARITH = 4'b0001,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    // register-form sub-ops in insn[5:3]
    localparam logic [2:0] SUBOP_ADD = 3'b000;
    localparam logic [2:0] SUBOP_SUB = 3'b010;
    localparam logic [2:0] SUBOP_AND = 3'b000;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     is_load;
        logic     is_store;
    } decoded_t;

endpackage

//--- rtl/lc4_lane.sv
`timescale 1ns/1ps

module lc4_lane import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  logic    gwe,
    input  logic    i_reset,
    input  slot_t   i_issue,
    input  word_t   i_rs,
    input  word_t   i_rt,
    input  word_t   i_st,
    input  word_t   i_dmem_data,
    output slot_t   o_x,
    output slot_t   o_m_slot,
    output word_t   o_m_rt,
    output fwd_t    o_m_fwd,
    output fwd_t    o_w_fwd,
    output logic    o_dmem_req,
    output word_t   o_dmem_addr,
    output retire_t o_retire
);

    slot_t x_q;
    slot_t m_q;
    slot_t w_q;
    word_t alu_result;
    word_t m_alu_q;
    word_t m_rt_q;
    word_t w_alu_q;
    word_t w_ld_q;
    word_t w_st_q;
    word_t wb_data;
    logic  m_mem;
    logic  w_mem;

    lc4_alu u_alu (
        .i_insn   (x_q.insn),
        .i_rs     (i_rs),
        .i_rt     (i_rt),
        .o_result (alu_result)
    );

    always_ff @(posedge gwe) begin
        x_q <= i_issue;
        m_q <= x_q;
        w_q <= m_q;
        if (i_reset) begin
            x_q.valid <= 1'b0;
            m_q.valid <= 1'b0;
            w_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge gwe) begin
        m_alu_q <= alu_result;
        m_rt_q  <= i_rt;
        w_alu_q <= m_alu_q;
        w_ld_q  <= i_dmem_data;
        w_st_q  <= i_st;
    end

    assign m_mem   = m_q.dec.is_load || m_q.dec.is_store;
    assign w_mem   = w_q.dec.is_load || w_q.dec.is_store;
    assign wb_data = w_q.dec.is_load ? w_ld_q : w_alu_q;

    // a load in M has no data yet
    assign o_m_fwd = '{we: m_q.valid && m_q.dec.rf_we && !m_q.dec.is_load,
                       rd: m_q.dec.rd, value: m_alu_q};
    assign o_w_fwd = '{we: w_q.valid && w_q.dec.rf_we, rd: w_q.dec.rd, value: wb_data};

    assign o_x         = x_q;
    assign o_m_slot    = m_q;
    assign o_m_rt      = m_rt_q;
    assign o_dmem_req  = m_q.valid && m_mem;
    assign o_dmem_addr = m_alu_q;

    always_comb begin
        o_retire.valid     = w_q.valid;
        o_retire.pc        = w_q.pc;
        o_retire.insn      = w_q.insn;
        o_retire.rf_we     = w_q.valid && w_q.dec.rf_we;
        o_retire.wsel      = w_q.dec.rf_we ? w_q.dec.rd : '0;
        o_retire.rf_data   = w_q.dec.rf_we ? wb_data : '0;
        o_retire.dmem_we   = w_q.valid && w_q.dec.is_store;
        o_retire.dmem_addr = w_mem ? w_alu_q : '0;
        o_retire.dmem_data = w_q.dec.is_load  ? w_ld_q :
                             w_q.dec.is_store ? w_st_q : '0;
    end

endmodule

//--- rtl/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

    import lc4_isa_pkg::*;

    // one instruction moving between stages
    typedef struct packed {
        word_t    pc;
        word_t    insn;
        decoded_t dec;
        logic     valid;
    } slot_t;

    // a lane's result offer to the bypass network
    typedef struct packed {
        logic     we;
        reg_sel_t rd;
        word_t    value;
    } fwd_t;

    // what one slot reports when it leaves writeback
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    rf_data;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } retire_t;

endpackage

//--- rtl/lc4_regfile_ss.sv
`timescale 1ns/1ps

module lc4_regfile_ss import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  logic     gwe,
    input  logic     i_reset,
    input  reg_sel_t i_rs_a,
    input  reg_sel_t i_rt_a,
    input  reg_sel_t i_rs_b,
    input  reg_sel_t i_rt_b,
    output word_t    o_rs_a,
    output word_t    o_rt_a,
    output word_t    o_rs_b,
    output word_t    o_rt_b,
    input  fwd_t     i_wr_a,
    input  fwd_t     i_wr_b
);

    localparam int unsigned NREGS = 2 ** REG_SEL_W;

    word_t regs_q [NREGS];

    // same-cycle writes show on the read side with slot B first
    function automatic word_t read_port(reg_sel_t sel);
        if (i_wr_b.we && i_wr_b.rd == sel) begin
            return i_wr_b.value;
        end else if (i_wr_a.we && i_wr_a.rd == sel) begin
            return i_wr_a.value;
        end
        return regs_q[sel];
    endfunction

    assign o_rs_a = read_port(i_rs_a);
    assign o_rt_a = read_port(i_rt_a);
    assign o_rs_b = read_port(i_rs_b);
    assign o_rt_b = read_port(i_rt_b);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (i_wr_a.we) begin
                regs_q[i_wr_a.rd] <= i_wr_a.value;
            end
            // B is younger, so it lands last
            if (i_wr_b.we) begin
                regs_q[i_wr_b.rd] <= i_wr_b.value;
            end
        end
    end

endmodule

//--- rtl/lc4_superscalar.sv
`timescale 1ns/1ps

module lc4_superscalar import lc4_isa_pkg::*, lc4_pipe_pkg::*; #(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic    gwe,
    input  logic    i_reset,
    output word_t   o_cur_pc,
    input  word_t   i_insn_a,
    input  word_t   i_insn_b,
    output word_t   o_dmem_addr,
    output word_t   o_dmem_towrite,
    output logic    o_dmem_we,
    input  word_t   i_dmem_data,
    output retire_t o_retire_a,
    output retire_t o_retire_b
);

    word_t    pc_q;
    slot_t    d_a_q, d_b_q;
    slot_t    fetch_a, fetch_b;
    slot_t    issue_a, issue_b;
    decoded_t dec_f_a, dec_f_b;
    logic     stall, pipe_switch, bubble_b;
    slot_t    x_a, x_b, m_slot_a, m_slot_b;
    word_t    rf_rs_a, rf_rt_a, rf_rs_b, rf_rt_b;
    word_t    rs_a, rt_a, rs_b, rt_b, st_a, st_b;
    word_t    m_rt_a, m_rt_b;
    fwd_t     m_fwd_a, m_fwd_b, w_fwd_a, w_fwd_b;
    logic     req_a, req_b;
    word_t    addr_a, addr_b;

    // the fetched pair is decoded on its way into the decode registers
    lc4_decoder u_dec_a (.i_insn(i_insn_a), .o_dec(dec_f_a));
    lc4_decoder u_dec_b (.i_insn(i_insn_b), .o_dec(dec_f_b));

    assign fetch_a = '{pc: pc_q, insn: i_insn_a, dec: dec_f_a, valid: 1'b1};
    assign fetch_b = '{pc: pc_q + word_t'(1), insn: i_insn_b, dec: dec_f_b, valid: 1'b1};

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q        <= RESET_PC;
            d_a_q.valid <= 1'b0;
            d_b_q.valid <= 1'b0;
        end else if (!stall) begin
            if (pipe_switch) begin
                // A goes alone, B slides over and the word at pc refills B
                d_a_q <= d_b_q;
                d_b_q <= fetch_a;
                pc_q  <= pc_q + word_t'(1);
            end else begin
                d_a_q <= fetch_a;
                d_b_q <= fetch_b;
                pc_q  <= pc_q + word_t'(2);
            end
        end
    end

    always_comb begin
        issue_a = d_a_q;
        issue_b = d_b_q;
        if (stall) begin
            issue_a.valid = 1'b0;
        end
        if (bubble_b) begin
            issue_b.valid = 1'b0;
        end
    end

    lc4_hazard_unit u_hazard (
        .i_d_a(d_a_q), .i_d_b(d_b_q), .i_x_a(x_a), .i_x_b(x_b),
        .o_switch(pipe_switch), .o_stall(stall), .o_bubble_b(bubble_b)
    );

    // operands are read with the execute-stage selects
    lc4_regfile_ss u_regfile (
        .gwe(gwe), .i_reset(i_reset),
        .i_rs_a(x_a.dec.rs), .i_rt_a(x_a.dec.rt), .i_rs_b(x_b.dec.rs), .i_rt_b(x_b.dec.rt),
        .o_rs_a(rf_rs_a), .o_rt_a(rf_rt_a), .o_rs_b(rf_rs_b), .o_rt_b(rf_rt_b),
        .i_wr_a(w_fwd_a), .i_wr_b(w_fwd_b)
    );

    lc4_bypass u_bypass (
        .i_x_a(x_a), .i_x_b(x_b),
        .i_rf_rs_a(rf_rs_a), .i_rf_rt_a(rf_rt_a), .i_rf_rs_b(rf_rs_b), .i_rf_rt_b(rf_rt_b),
        .i_m_a(m_fwd_a), .i_m_b(m_fwd_b), .i_w_a(w_fwd_a), .i_w_b(w_fwd_b),
        .i_m_slot_a(m_slot_a), .i_m_slot_b(m_slot_b), .i_m_rt_a(m_rt_a), .i_m_rt_b(m_rt_b),
        .o_rs_a(rs_a), .o_rt_a(rt_a), .o_rs_b(rs_b), .o_rt_b(rt_b),
        .o_st_a(st_a), .o_st_b(st_b)
    );

    lc4_lane u_lane_a (
        .gwe(gwe), .i_reset(i_reset), .i_issue(issue_a),
        .i_rs(rs_a), .i_rt(rt_a), .i_st(st_a), .i_dmem_data(i_dmem_data),
        .o_x(x_a), .o_m_slot(m_slot_a), .o_m_rt(m_rt_a),
        .o_m_fwd(m_fwd_a), .o_w_fwd(w_fwd_a),
        .o_dmem_req(req_a), .o_dmem_addr(addr_a), .o_retire(o_retire_a)
    );

    lc4_lane u_lane_b (
        .gwe(gwe), .i_reset(i_reset), .i_issue(issue_b),
        .i_rs(rs_b), .i_rt(rt_b), .i_st(st_b), .i_dmem_data(i_dmem_data),
        .o_x(x_b), .o_m_slot(m_slot_b), .o_m_rt(m_rt_b),
        .o_m_fwd(m_fwd_b), .o_w_fwd(w_fwd_b),
        .o_dmem_req(req_b), .o_dmem_addr(addr_b), .o_retire(o_retire_b)
    );

    // at most one lane is in M with a memory op
    always_comb begin
        o_dmem_addr    = '0;
        o_dmem_we      = 1'b0;
        o_dmem_towrite = '0;
        if (req_a) begin
            o_dmem_addr    = addr_a;
            o_dmem_we      = m_slot_a.dec.is_store;
            o_dmem_towrite = st_a;
        end else if (req_b) begin
            o_dmem_addr    = addr_b;
            o_dmem_we      = m_slot_b.dec.is_store;
            o_dmem_towrite = st_b;
        end
    end

    assign o_cur_pc = pc_q;

endmodule
